// ==== verilog.f ====
logic/ahb_sram_pkg.sv
logic/sram_1r1w.sv
logic/ahb_sram_slave.sv
logic/ahb_bank_decoder.sv
logic/ahb_sram_subsystem.sv
sim/tb_clock_gen.sv
sim/ahb_sram_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the AHB SRAM subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module ahb_sram_tb \
  -f verilog.f \
  -Mdir obj_dir \
  -o sim_ahb_sram
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_ahb_sram)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1

// ==== sim/ahb_sram_tb.sv ====
`default_nettype none

module ahb_sram_tb
  import ahb_sram_pkg::*;
;

  localparam int     MEM_DEPTH   = 256;
  localparam int     TIMEOUT     = 20;
  // Bank bit just above the word address
  localparam int     BANK_BIT    = 2 + $clog2(MEM_DEPTH);
  localparam haddr_t BANK_MASK   = haddr_t'(1) << BANK_BIT;
  localparam int     MODEL_BYTES = 2 * MEM_DEPTH * 4;

  logic    HCLK;
  logic    HRESETn;
  logic    hsel;
  haddr_t  haddr;
  hdata_t  hwdata;
  logic    hwrite;
  hsize_t  hsize;
  htrans_t htrans;
  hdata_t  hrdata;
  logic    hreadyout;
  logic    hresp;

  tb_clock_gen #(
    .PERIOD       (20),
    .RESET_CYCLES (2)
  ) u_clk (
    .HCLK    (HCLK),
    .HRESETn (HRESETn)
  );

  // Single master, ready loops straight back
  ahb_sram_subsystem #(
    .MEM_DEPTH (MEM_DEPTH)
  ) DUT (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .hsel      (hsel),
    .haddr     (haddr),
    .hwdata    (hwdata),
    .hwrite    (hwrite),
    .hsize     (hsize),
    .htrans    (htrans),
    .hready    (hreadyout),
    .hrdata    (hrdata),
    .hreadyout (hreadyout),
    .hresp     (hresp)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and bookkeeping
  ////////////////////////////////////////////////////////////////////////////

  // Bytes indexed by {bank, word, lane}
  logic [7:0]  model [0:MODEL_BYTES-1];
  logic [31:0] lfsr_state = 32'hf666_8ac8;

  int errors       = 0;
  int tests_run    = 0;
  int tests_failed = 0;
  int stall_cycles = 0;

  // Bus stuck, later bus cycles are skipped
  logic timed_out = 1'b0;

  // Transfer now in its data phase
  logic   pend_valid = 1'b0;
  logic   pend_write = 1'b0;
  haddr_t pend_addr  = '0;
  hsize_t pend_size  = WORD;
  hdata_t pend_wdata = '0;

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // High address bits alias, only bank and word count
  function automatic int model_base(input haddr_t addr);
    return 4 * int'(addr[BANK_BIT:2]);
  endfunction

  function automatic hdata_t model_read(input haddr_t addr);
    hdata_t w;
    int     base;
    base = model_base(addr);
    for (int i = 0; i < 4; i++) begin
      w[i*8 +: 8] = model[base + i];
    end
    return w;
  endfunction

  // Size lanes moved to the addressed byte
  task automatic model_write(input haddr_t addr, input hsize_t size, input hdata_t data);
    be_t lanes;
    int  base;
    case (size)
      BYTE:    lanes = 4'b0001;
      HWORD:   lanes = 4'b0011;
      default: lanes = 4'b1111;
    endcase
    lanes = lanes << addr[1:0];
    base  = model_base(addr);
    for (int i = 0; i < 4; i++) begin
      if (lanes[i]) begin
        model[base + i] = data[i*8 +: 8];
      end
    end
  endtask

  function automatic hdata_t fill_pattern(input haddr_t addr);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Bus driver
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_timeout(input string reason);
    $display("%s", reason);
    timed_out = 1'b1;
    errors++;
  endtask

  // One address phase, overlapping the previous data phase
  // Called just after a rising edge, returns just after the accepting edge
  task automatic bus_cycle(input htrans_t trans, input haddr_t addr, input logic write,
                           input hsize_t size, input hdata_t wdata);
    int     waits;
    hdata_t exp;
    if (timed_out) begin
      return;
    end
    htrans <= trans;
    haddr  <= addr;
    hwrite <= write;
    hsize  <= size;
    hwdata <= pend_wdata;
    // Sample on the falling edge, away from the DUT updates
    waits = 0;
    @(negedge HCLK);
    while (!hreadyout && waits < TIMEOUT) begin
      waits++;
      @(negedge HCLK);
    end
    if (waits >= TIMEOUT) begin
      report_timeout("Timeout: hreadyout stayed low for 20 cycles");
      return;
    end
    stall_cycles += waits;
    assert (hresp === 1'b0) else begin
      $display("Error: hresp expected %h got %h", 1'b0, hresp);
      errors++;
    end
    if (pend_valid && !pend_write) begin
      exp = model_read(pend_addr);
      assert (hrdata === exp) else begin
        $display("Error: hrdata at %h expected %h got %h", pend_addr, exp, hrdata);
        errors++;
      end
    end
    @(posedge HCLK);
    // Write lands on this edge
    if (pend_valid && pend_write) begin
      model_write(pend_addr, pend_size, pend_wdata);
    end
    pend_valid = (trans == NONSEQ) || (trans == SEQ);
    pend_write = write;
    pend_addr  = addr;
    pend_size  = size;
    pend_wdata = wdata;
  endtask

  task automatic idle_cycle();
    bus_cycle(IDLE, '0, 1'b0, WORD, '0);
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    tests_run++;
    if (errors == errs_at_start && !timed_out) begin
      $display("%-24s ok", name);
    end else begin
      tests_failed++;
      $display("%-24s FAILED, %0d errors", name, errors - errs_at_start);
    end
  endtask

  task automatic check_stalls(input int expected);
    assert (stall_cycles == expected) else begin
      $display("Error: hreadyout low cycles expected %h got %h", expected, stall_cycles);
      errors++;
    end
  endtask

  // Every word of both banks gets a known value
  task automatic fill_memory();
    haddr_t a;
    for (int i = 0; i < 2 * MEM_DEPTH; i++) begin
      a = haddr_t'(i * 4);
      bus_cycle(NONSEQ, a, 1'b1, WORD, fill_pattern(a));
    end
    idle_cycle();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    int e0;
    int waits;
    e0    = errors;
    waits = 0;
    do begin
      @(negedge HCLK);
      assert (hreadyout === 1'b1) else begin
        $display("Error: hreadyout expected %h got %h", 1'b1, hreadyout);
        errors++;
      end
      assert (hresp === 1'b0) else begin
        $display("Error: hresp expected %h got %h", 1'b0, hresp);
        errors++;
      end
      waits++;
    end while (!HRESETn && waits < TIMEOUT);
    if (!HRESETn) begin
      report_timeout("Timeout: reset never released");
    end else begin
      @(posedge HCLK);
    end
    stall_cycles = 0;
    repeat (3) idle_cycle();
    check_stalls(0);
    report_test("reset_state", e0);
  endtask

  task automatic test_word_access();
    int     e0;
    haddr_t a;
    e0 = errors;
    // Same word index in both banks, different data
    for (int i = 0; i < 4; i++) begin
      a = haddr_t'(i * 36);
      bus_cycle(NONSEQ, a, 1'b1, WORD, rand_bits(32));
      bus_cycle(NONSEQ, a | BANK_MASK, 1'b1, WORD, rand_bits(32));
    end
    for (int i = 0; i < 4; i++) begin
      a = haddr_t'(i * 36);
      bus_cycle(NONSEQ, a, 1'b0, WORD, '0);
      bus_cycle(NONSEQ, a | BANK_MASK, 1'b0, WORD, '0);
    end
    // Bits above the bank bit are ignored
    bus_cycle(NONSEQ, 32'hf000_0024, 1'b0, WORD, '0);
    bus_cycle(NONSEQ, 32'h0abc_0024 | BANK_MASK, 1'b0, WORD, '0);
    idle_cycle();
    report_test("word_access", e0);
  endtask

  task automatic test_partial_writes();
    int     e0;
    int     off;
    haddr_t base;
    hsize_t size;
    e0 = errors;
    for (int b = 0; b < 2; b++) begin
      base = (b == 1) ? (BANK_MASK | 32'h80) : 32'h80;
      // Four byte lanes then two halfword lanes
      for (int k = 0; k < 6; k++) begin
        size = (k < 4) ? BYTE : HWORD;
        off  = (k < 4) ? k : (k - 4) * 2;
        bus_cycle(NONSEQ, base, 1'b1, WORD, fill_pattern(base));
        bus_cycle(NONSEQ, base + haddr_t'(off), 1'b1, size, rand_bits(32));
        idle_cycle();
        bus_cycle(NONSEQ, base, 1'b0, WORD, '0);
        idle_cycle();
      end
    end
    report_test("partial_writes", e0);
  endtask

  task automatic test_full_write_read();
    int     e0;
    haddr_t a;
    e0 = errors;
    for (int b = 0; b < 2; b++) begin
      a = (b == 1) ? (BANK_MASK | 32'h100) : 32'h100;
      stall_cycles = 0;
      // Read rides the memory bypass
      bus_cycle(NONSEQ, a, 1'b1, WORD, rand_bits(32));
      bus_cycle(NONSEQ, a, 1'b0, WORD, '0);
      idle_cycle();
      check_stalls(0);
    end
    report_test("full_write_then_read", e0);
  endtask

  task automatic test_partial_write_read();
    int     e0;
    haddr_t a;
    e0 = errors;
    for (int b = 0; b < 2; b++) begin
      a = (b == 1) ? (BANK_MASK | 32'h140) : 32'h140;
      stall_cycles = 0;
      bus_cycle(NONSEQ, a + 32'h1, 1'b1, BYTE, rand_bits(32));
      bus_cycle(NONSEQ, a, 1'b0, WORD, '0);
      idle_cycle();
      check_stalls(1);
      stall_cycles = 0;
      bus_cycle(NONSEQ, a + 32'h2, 1'b1, HWORD, rand_bits(32));
      bus_cycle(NONSEQ, a, 1'b0, WORD, '0);
      idle_cycle();
      check_stalls(1);
    end
    report_test("partial_write_then_read", e0);
  endtask

  task automatic test_random();
    int          e0;
    logic [31:0] kind;
    logic [31:0] sel;
    logic [31:0] off;
    haddr_t      a;
    hsize_t      size;
    htrans_t     trans;
    e0 = errors;
    for (int n = 0; n < 200; n++) begin
      kind  = rand_bits(3);
      trans = (kind == 0) ? IDLE : (kind == 1) ? BUSY : NONSEQ;
      sel   = rand_bits(2);
      case (sel)
        0:       size = BYTE;
        1:       size = HWORD;
        default: size = WORD;
      endcase
      case (size)
        BYTE:    off = rand_bits(2);
        HWORD:   off = rand_bits(1) << 1;
        default: off = 0;
      endcase
      // Few words, so the same word is hit back to back
      a = (rand_bits(4) << (BANK_BIT + 1)) | (rand_bits(1) << BANK_BIT)
        | (rand_bits(3) << 2) | off;
      bus_cycle(trans, a, rand_bits(1) == 1, size, rand_bits(32));
    end
    idle_cycle();
    // Sweep the words touched, catches writes from IDLE or BUSY
    for (int i = 0; i < 16; i++) begin
      a = ((haddr_t'(i) >> 3) << BANK_BIT) | (haddr_t'(i % 8) << 2);
      bus_cycle(NONSEQ, a, 1'b0, WORD, '0);
    end
    idle_cycle();
    report_test("random_sequence", e0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    hsel   = 1'b1;
    haddr  = '0;
    hwdata = '0;
    hwrite = 1'b0;
    hsize  = WORD;
    htrans = IDLE;

    test_reset();
    fill_memory();
    test_word_access();
    test_partial_writes();
    test_full_write_read();
    test_partial_write_read();
    test_random();

    $display("Tests: %0d run, %0d ok, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 2
) (
  output logic HCLK,
  output logic HRESETn
);

  initial begin
    HCLK = 1'b0;
    forever #(PERIOD / 2) HCLK = ~HCLK;
  end

  // Release on a rising edge, after the flops have seen it
  initial begin
    HRESETn = 1'b0;
    repeat (RESET_CYCLES) @(posedge HCLK);
    HRESETn <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== logic/ahb_sram_subsystem.sv ====
`default_nettype none

module ahb_sram_subsystem
  import ahb_sram_pkg::*;
#(
  parameter int MEM_DEPTH = 256
) (
  input  wire logic    HCLK,
  input  wire logic    HRESETn,

  input  wire logic    hsel,
  input  wire haddr_t  haddr,
  input  wire hdata_t  hwdata,
  input  wire logic    hwrite,
  input  wire hsize_t  hsize,
  input  wire htrans_t htrans,
  input  wire logic    hready,

  output hdata_t       hrdata,
  output logic         hreadyout,
  output logic         hresp
);

  ////////////////////////////////////////////////////////////////////////////
  // Bank wiring
  ////////////////////////////////////////////////////////////////////////////

  logic   hsel_bank0;
  logic   hsel_bank1;
  hdata_t hrdata_bank0;
  hdata_t hrdata_bank1;
  logic   hreadyout_bank0;
  logic   hreadyout_bank1;
  logic   hresp_bank0;
  logic   hresp_bank1;

  ahb_bank_decoder #(
    .MEM_DEPTH (MEM_DEPTH)
  ) u_decoder (
    .HCLK            (HCLK),
    .HRESETn         (HRESETn),
    .hsel            (hsel),
    .haddr           (haddr),
    .hready          (hready),
    .hsel_bank0      (hsel_bank0),
    .hsel_bank1      (hsel_bank1),
    .hrdata_bank0    (hrdata_bank0),
    .hrdata_bank1    (hrdata_bank1),
    .hreadyout_bank0 (hreadyout_bank0),
    .hreadyout_bank1 (hreadyout_bank1),
    .hrdata          (hrdata),
    .hreadyout       (hreadyout)
  );

  // Both banks see the shared bus hready
  ahb_sram_slave #(
    .MEM_DEPTH (MEM_DEPTH)
  ) bank0 (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .hsel      (hsel_bank0),
    .haddr     (haddr),
    .hwrite    (hwrite),
    .hsize     (hsize),
    .htrans    (htrans),
    .hready    (hready),
    .hwdata    (hwdata),
    .hrdata    (hrdata_bank0),
    .hreadyout (hreadyout_bank0),
    .hresp     (hresp_bank0)
  );

  ahb_sram_slave #(
    .MEM_DEPTH (MEM_DEPTH)
  ) bank1 (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .hsel      (hsel_bank1),
    .haddr     (haddr),
    .hwrite    (hwrite),
    .hsize     (hsize),
    .htrans    (htrans),
    .hready    (hready),
    .hwdata    (hwdata),
    .hrdata    (hrdata_bank1),
    .hreadyout (hreadyout_bank1),
    .hresp     (hresp_bank1)
  );

  // Error from either bank
  assign hresp = hresp_bank0 | hresp_bank1;

endmodule

`default_nettype wire

// ==== logic/ahb_bank_decoder.sv ====
`default_nettype none

module ahb_bank_decoder
  import ahb_sram_pkg::*;
#(
  parameter int MEM_DEPTH = 256
) (
  input  wire logic   HCLK,
  input  wire logic   HRESETn,

  // Address phase from the master
  input  wire logic   hsel,
  input  wire haddr_t haddr,
  input  wire logic   hready,

  // Per bank selects
  output logic        hsel_bank0,
  output logic        hsel_bank1,

  // Bank responses
  input  wire hdata_t hrdata_bank0,
  input  wire hdata_t hrdata_bank1,
  input  wire logic   hreadyout_bank0,
  input  wire logic   hreadyout_bank1,

  // Muxed response
  output hdata_t      hrdata,
  output logic        hreadyout
);

  // Bank bit sits just above the word address
  localparam int BANK_BIT = 2 + $clog2(MEM_DEPTH);

  logic bank;

  // Data phase owner
  logic dp_sel;
  logic dp_bank;

  ////////////////////////////////////////////////////////////////////////////
  // Address phase select
  ////////////////////////////////////////////////////////////////////////////

  assign bank       = haddr[BANK_BIT];
  assign hsel_bank0 = hsel & ~bank;
  assign hsel_bank1 = hsel & bank;

  // Remember who owns the next data phase
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      dp_sel  <= 1'b0;
      dp_bank <= 1'b0;
    end else if (hready) begin
      dp_sel  <= hsel;
      dp_bank <= bank;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Data phase response
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Nobody selected, keep the bus moving
    hrdata    = '0;
    hreadyout = 1'b1;
    if (dp_sel) begin
      if (dp_bank) begin
        hrdata    = hrdata_bank1;
        hreadyout = hreadyout_bank1;
      end else begin
        hrdata    = hrdata_bank0;
        hreadyout = hreadyout_bank0;
      end
    end
  end

  // Only the bank owning the data phase may hold the bus
  a_owner_stalls: assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    (hreadyout_bank0 || (dp_sel && !dp_bank)) &&
    (hreadyout_bank1 || (dp_sel && dp_bank))
  );

endmodule

`default_nettype wire

// ==== logic/ahb_sram_slave.sv ====
`default_nettype none

module ahb_sram_slave
  import ahb_sram_pkg::*;
#(
  parameter int MEM_DEPTH = 256
) (
  input  wire logic    HCLK,
  input  wire logic    HRESETn,

  // Address phase
  input  wire logic    hsel,
  input  wire haddr_t  haddr,
  input  wire logic    hwrite,
  input  wire hsize_t  hsize,
  input  wire htrans_t htrans,
  input  wire logic    hready,

  // Data phase
  input  wire hdata_t  hwdata,
  output hdata_t       hrdata,
  output logic         hreadyout,
  output logic         hresp
);

  ////////////////////////////////////////////////////////////////////////////
  // Constants
  ////////////////////////////////////////////////////////////////////////////

  localparam int ABITS  = $clog2(MEM_DEPTH);
  // Byte offset bits below the word address
  localparam int BE_LSB = $clog2(BE_SIZE);

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  logic             active;
  logic [ABITS-1:0] word_addr;

  // Captured at the end of the address phase
  logic             we_q;
  be_t              be_q;
  logic [ABITS-1:0] dp_addr;

  logic             mem_we;
  logic [ABITS-1:0] rd_addr;
  logic             contention;
  logic             stall;

  // Lane pattern for the size, moved up to the addressed byte
  function automatic be_t gen_be(input hsize_t size, input logic [BE_LSB-1:0] offset);
    be_t lanes;
    case (size)
      BYTE:    lanes = be_t'(1);
      HWORD:   lanes = be_t'(3);
      default: lanes = '1;
    endcase
    return lanes << offset;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Address phase capture
  ////////////////////////////////////////////////////////////////////////////

  assign active    = hsel & ((htrans == NONSEQ) | (htrans == SEQ));
  // Bits above the word address are ignored here
  assign word_addr = haddr[BE_LSB +: ABITS];

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      we_q <= 1'b0;
    end else if (hready) begin
      we_q <= active & hwrite;
    end
  end

  // Lanes and word of the transfer now in its data phase
  always_ff @(posedge HCLK) begin
    if (hready) begin
      be_q    <= gen_be(hsize, haddr[BE_LSB-1:0]);
      dp_addr <= word_addr;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Memory
  ////////////////////////////////////////////////////////////////////////////

  // Write lands on the edge closing the data phase, hwdata valid then
  assign mem_we = we_q & hready;

  // Stalled read has to fetch its own word again
  // Master is already showing the next address
  assign rd_addr = hreadyout ? word_addr : dp_addr;

  sram_1r1w #(
    .ABITS     (ABITS),
    .MEM_DEPTH (MEM_DEPTH)
  ) u_mem (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .waddr   (dp_addr),
    .we      (mem_we),
    .be      (be_q),
    .din     (hwdata),
    .raddr   (rd_addr),
    .dout    (hrdata)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Read after write
  ////////////////////////////////////////////////////////////////////////////

  // Pending write and new read hit the same word
  assign contention = mem_we & active & ~hwrite & (dp_addr == word_addr);

  // Full word goes through memory bypass, partial needs a wait state
  assign stall = contention & ~(&be_q);

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      hreadyout <= 1'b1;
    end else begin
      hreadyout <= ~stall;
    end
  end

  assign hresp = HRESP_OKAY;

  // Single wait state per contention
  a_one_wait: assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    !hreadyout |=> hreadyout
  );

  a_we_known: assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    !$isunknown(we_q)
  );

endmodule

`default_nettype wire

// ==== logic/sram_1r1w.sv ====
`default_nettype none

module sram_1r1w
  import ahb_sram_pkg::*;
#(
  parameter int ABITS     = 8,
  parameter int MEM_DEPTH = 256
) (
  input  wire logic             HCLK,
  input  wire logic             HRESETn,

  // Write port
  input  wire logic [ABITS-1:0] waddr,
  input  wire logic             we,
  input  wire be_t              be,
  input  wire hdata_t           din,

  // Read port
  input  wire logic [ABITS-1:0] raddr,
  output hdata_t                dout
);

  // Storage array
  hdata_t mem [0:MEM_DEPTH-1];

  // Full word write on the port being read
  logic fwd;

  assign fwd = we & (&be) & (waddr == raddr);

  ////////////////////////////////////////////////////////////////////////////
  // Write port, byte granular
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK) begin
    if (we) begin
      for (int i = 0; i < BE_SIZE; i++) begin
        if (be[i]) begin
          mem[waddr][i*8 +: 8] <= din[i*8 +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read port, one edge from address to data
  ////////////////////////////////////////////////////////////////////////////

  // Array read returns old contents on a collision
  // Full word writes bypass straight to the output
  // Partial collisions are the slave's problem
  always_ff @(posedge HCLK) begin
    if (fwd) begin
      dout <= din;
    end else begin
      dout <= mem[raddr];
    end
  end

  // Slave never issues a write with no lanes
  a_we_has_lanes: assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    we |-> (be != '0)
  );

endmodule

`default_nettype wire

// ==== logic/ahb_sram_pkg.sv ====
`default_nettype none

package ahb_sram_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int HADDR_SIZE = 32;
  localparam int HDATA_SIZE = 32;

  // One enable per byte lane
  localparam int BE_SIZE = (HDATA_SIZE + 7) / 8;

  typedef logic [HADDR_SIZE-1:0] haddr_t;
  typedef logic [HDATA_SIZE-1:0] hdata_t;
  typedef logic [BE_SIZE-1:0]    be_t;

  ////////////////////////////////////////////////////////////////////////////
  // Transfer encodings
  ////////////////////////////////////////////////////////////////////////////

  // HTRANS, only NONSEQ and SEQ move data
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  // HSIZE up to the bus width
  // Wider codes fall back to a full word
  typedef enum logic [2:0] {
    BYTE  = 3'b000,
    HWORD = 3'b001,
    WORD  = 3'b010
  } hsize_t;

  ////////////////////////////////////////////////////////////////////////////
  // Response
  ////////////////////////////////////////////////////////////////////////////

  // No error path, slave always answers OKAY
  localparam logic HRESP_OKAY = 1'b0;

endpackage

`default_nettype wire
